// File: hw/soc_mem_pkg.sv
package soc_mem_pkg;

    // Bus widths
    localparam int DATA_W = 32;
    localparam int ADDR_W = 32;
    localparam int BE_W   = 4;

    // Address map
    localparam logic [ADDR_W-1:0] SRAM_BASE     = 32'h8000_0000;
    localparam logic [ADDR_W-1:0] HOST_REMAP_LO = 32'h3000_0000;
    localparam logic [ADDR_W-1:0] HOST_REMAP_HI = 32'h8000_0000;
    localparam logic [3:0]        REMAP_NIBBLE  = 4'h8;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } mem_op_e;

    typedef enum logic {
        PORT_CORE = 1'b0,
        PORT_HOST = 1'b1
    } port_id_e;

    // SRAM window test, 4 << words_log2 bytes from SRAM_BASE.
    // An address below the base wraps to a large offset and fails too
    function automatic logic in_sram_window(input logic [ADDR_W-1:0] addr,
                                            input int unsigned words_log2);
        logic [ADDR_W-1:0] offset;
        offset = addr - SRAM_BASE;
        return (offset >> (words_log2 + 2)) == '0;
    endfunction

endpackage

// File: hw/host_addr_remap.sv
`timescale 1ns/1ps

module host_addr_remap #(
    parameter int ADDR_WORDS = 8
) (
    input  logic                           host_en_i,
    input  logic                           req_valid_i,
    input  logic [soc_mem_pkg::ADDR_W-1:0] addr_i,
    output logic                           req_valid_o,
    output logic [soc_mem_pkg::ADDR_W-1:0] addr_o,
    output logic                           in_window_o
);

    logic in_remap;

    // Host port is dead while disabled
    assign req_valid_o = host_en_i && req_valid_i;

    assign in_remap = (addr_i >= soc_mem_pkg::HOST_REMAP_LO) &&
                      (addr_i <  soc_mem_pkg::HOST_REMAP_HI);

    always_comb begin
        if (in_remap) begin
            // Swap the top nibble so the host window lands on SRAM
            addr_o = {soc_mem_pkg::REMAP_NIBBLE, addr_i[soc_mem_pkg::ADDR_W-5:0]};
        end else begin
            addr_o = addr_i;
        end
    end

    // Checked after the remap
    assign in_window_o = soc_mem_pkg::in_sram_window(addr_o, ADDR_WORDS);

endmodule

// File: hw/req_arbiter.sv
`timescale 1ns/1ps

module req_arbiter #(
    parameter int ADDR_WORDS = 8
) (
    // Core request
    input  logic                           core_valid_i,
    input  soc_mem_pkg::mem_op_e           core_op_i,
    input  logic [soc_mem_pkg::ADDR_W-1:0] core_addr_i,
    input  logic [soc_mem_pkg::BE_W-1:0]   core_be_i,
    input  logic [soc_mem_pkg::DATA_W-1:0] core_wdata_i,
    output logic                           core_ready_o,

    // Host request after the remap
    input  logic                           host_valid_i,
    input  soc_mem_pkg::mem_op_e           host_op_i,
    input  logic [soc_mem_pkg::ADDR_W-1:0] host_addr_i,
    input  logic                           host_in_window_i,
    input  logic [soc_mem_pkg::BE_W-1:0]   host_be_i,
    input  logic [soc_mem_pkg::DATA_W-1:0] host_wdata_i,
    output logic                           host_ready_o,

    // Room left on the response side
    input  logic                           core_credit_i,
    input  logic                           host_credit_i,

    // Stage request into the SRAM
    output logic                           stg_valid_o,
    output soc_mem_pkg::mem_op_e           stg_op_o,
    output logic [ADDR_WORDS-1:0]          stg_index_o,
    output logic [soc_mem_pkg::BE_W-1:0]   stg_be_o,
    output logic [soc_mem_pkg::DATA_W-1:0] stg_wdata_o,
    output logic                           stg_err_o,
    output soc_mem_pkg::port_id_e          stg_tag_o
);

    logic                           host_take;
    logic                           core_take;
    logic                           core_in_window;
    logic [soc_mem_pkg::ADDR_W-1:0] sel_addr;

    // Host has fixed priority over the core
    assign host_take    = host_valid_i && host_credit_i;
    assign host_ready_o = host_take;

    assign core_ready_o = core_credit_i && !host_take;
    assign core_take    = core_valid_i && core_ready_o;

    assign core_in_window = soc_mem_pkg::in_sram_window(core_addr_i, ADDR_WORDS);

    assign stg_valid_o = host_take || core_take;

    always_comb begin
        if (host_take) begin
            stg_op_o    = host_op_i;
            sel_addr    = host_addr_i;
            stg_be_o    = host_be_i;
            stg_wdata_o = host_wdata_i;
            stg_err_o   = !host_in_window_i;
            stg_tag_o   = soc_mem_pkg::PORT_HOST;
        end else begin
            stg_op_o    = core_op_i;
            sel_addr    = core_addr_i;
            stg_be_o    = core_be_i;
            stg_wdata_o = core_wdata_i;
            stg_err_o   = !core_in_window;
            stg_tag_o   = soc_mem_pkg::PORT_CORE;
        end
    end

    // Byte address to word index
    assign stg_index_o = sel_addr[ADDR_WORDS+1:2];

endmodule

// File: hw/sram_bank.sv
`timescale 1ns/1ps

module sram_bank #(
    parameter int ADDR_WORDS = 8
) (
    input  logic                           clk_i,
    input  logic                           rst_i,

    input  logic                           stg_valid_i,
    input  soc_mem_pkg::mem_op_e           stg_op_i,
    input  logic [ADDR_WORDS-1:0]          stg_index_i,
    input  logic [soc_mem_pkg::BE_W-1:0]   stg_be_i,
    input  logic [soc_mem_pkg::DATA_W-1:0] stg_wdata_i,
    input  logic                           stg_err_i,
    input  soc_mem_pkg::port_id_e          stg_tag_i,

    output logic                           res_valid_o,
    output logic [soc_mem_pkg::DATA_W-1:0] res_rdata_o,
    output logic                           res_err_o,
    output soc_mem_pkg::port_id_e          res_tag_o
);

    localparam int BYTE_W = soc_mem_pkg::DATA_W / soc_mem_pkg::BE_W;

    logic [soc_mem_pkg::DATA_W-1:0] mem [2**ADDR_WORDS];
    logic                           wr_en;
    logic                           rd_en;

    // Out-of-window accesses never reach the array
    assign wr_en = stg_valid_i && !stg_err_i && (stg_op_i == soc_mem_pkg::OP_WRITE);
    assign rd_en = stg_valid_i && !stg_err_i && (stg_op_i == soc_mem_pkg::OP_READ);

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            for (int b = 0; b < soc_mem_pkg::BE_W; b++) begin
                if (stg_be_i[b]) begin
                    mem[stg_index_i][b*BYTE_W +: BYTE_W] <= stg_wdata_i[b*BYTE_W +: BYTE_W];
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            res_valid_o <= 1'b0;
        end else begin
            res_valid_o <= stg_valid_i;
        end
    end

    // Read data is the word from before this access
    always_ff @(posedge clk_i) begin
        res_rdata_o <= rd_en ? mem[stg_index_i] : '0;
        res_err_o   <= stg_err_i;
        res_tag_o   <= stg_tag_i;
    end

    // Erroneous access leaves the addressed word as it was
    assert property (@(posedge clk_i) disable iff (rst_i)
        (stg_valid_i && stg_err_i) |=> (mem[$past(stg_index_i)] === $past(mem[stg_index_i])))
        else $error("sram_bank: erroneous access changed memory");

endmodule

// File: hw/rsp_router.sv
`timescale 1ns/1ps

module rsp_router (
    input  logic                           clk_i,
    input  logic                           rst_i,

    // Acceptances, for the outstanding counts
    input  logic                           stg_valid_i,
    input  soc_mem_pkg::port_id_e          stg_tag_i,

    // SRAM result
    input  logic                           res_valid_i,
    input  logic [soc_mem_pkg::DATA_W-1:0] res_rdata_i,
    input  logic                           res_err_i,
    input  soc_mem_pkg::port_id_e          res_tag_i,

    input  logic                           core_rsp_ready_i,
    input  logic                           host_rsp_ready_i,

    output logic                           core_rsp_valid_o,
    output logic [soc_mem_pkg::DATA_W-1:0] core_rsp_rdata_o,
    output logic                           core_rsp_err_o,
    output logic                           host_rsp_valid_o,
    output logic [soc_mem_pkg::DATA_W-1:0] host_rsp_rdata_o,
    output logic                           host_rsp_err_o,

    output logic                           core_credit_o,
    output logic                           host_credit_o,
    output logic                           illegal_o
);

    // Index 0 is PORT_CORE, index 1 is PORT_HOST
    localparam int NPORT = 2;

    logic [soc_mem_pkg::DATA_W-1:0] slot_rdata [NPORT][2];
    logic                           slot_err   [NPORT][2];
    logic [1:0]                     fill        [NPORT];
    logic [1:0]                     outstanding [NPORT];
    logic [NPORT-1:0]               wr_ptr;
    logic [NPORT-1:0]               rd_ptr;
    logic [NPORT-1:0]               acc;
    logic [NPORT-1:0]               push;
    logic [NPORT-1:0]               pop;
    logic [NPORT-1:0]               rsp_valid;
    logic [NPORT-1:0]               rsp_ready;
    logic [NPORT-1:0]               credit;
    logic [soc_mem_pkg::DATA_W-1:0] rsp_rdata  [NPORT];
    logic                           rsp_err    [NPORT];

    assign rsp_ready = {host_rsp_ready_i, core_rsp_ready_i};

    ////////////////////////////////////////////////////////////////////////////
    // Per-port bookkeeping
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int p = 0; p < NPORT; p++) begin
            acc[p]       = stg_valid_i && (int'(stg_tag_i) == p);
            push[p]      = res_valid_i && (int'(res_tag_i) == p);
            rsp_valid[p] = fill[p] != 2'd0;
            pop[p]       = rsp_valid[p] && rsp_ready[p];
            // Two items in flight at most, a slot freed this cycle counts
            credit[p]    = (outstanding[p] < 2'd2) || pop[p];
            rsp_rdata[p] = slot_rdata[p][rd_ptr[p]];
            rsp_err[p]   = slot_err[p][rd_ptr[p]];
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int p = 0; p < NPORT; p++) begin
                fill[p]        <= 2'd0;
                outstanding[p] <= 2'd0;
            end
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            illegal_o <= 1'b0;
        end else begin
            for (int p = 0; p < NPORT; p++) begin
                fill[p]        <= fill[p] + 2'(push[p]) - 2'(pop[p]);
                outstanding[p] <= outstanding[p] + 2'(acc[p]) - 2'(pop[p]);
                if (push[p]) begin
                    wr_ptr[p] <= ~wr_ptr[p];
                end
                if (pop[p]) begin
                    rd_ptr[p] <= ~rd_ptr[p];
                end
            end
            // Sticky until reset
            if (res_valid_i && res_err_i) begin
                illegal_o <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        for (int p = 0; p < NPORT; p++) begin
            if (push[p]) begin
                slot_rdata[p][wr_ptr[p]] <= res_rdata_i;
                slot_err[p][wr_ptr[p]]   <= res_err_i;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Port outputs
    ////////////////////////////////////////////////////////////////////////////

    assign core_rsp_valid_o = rsp_valid[0];
    assign core_rsp_rdata_o = rsp_rdata[0];
    assign core_rsp_err_o   = rsp_err[0];
    assign host_rsp_valid_o = rsp_valid[1];
    assign host_rsp_rdata_o = rsp_rdata[1];
    assign host_rsp_err_o   = rsp_err[1];
    assign core_credit_o    = credit[0];
    assign host_credit_o    = credit[1];

    for (genvar p = 0; p < NPORT; p++) begin : g_checks
        // Stalled response holds still
        assert property (@(posedge clk_i) disable iff (rst_i)
            (rsp_valid[p] && !rsp_ready[p]) |=>
                (rsp_valid[p] && $stable(rsp_rdata[p]) && $stable(rsp_err[p])))
            else $error("rsp_router: response changed while stalled");

        // Arbiter credit keeps results from landing on a full slot
        assert property (@(posedge clk_i) disable iff (rst_i)
            push[p] |-> ((fill[p] < 2'd2) || pop[p]))
            else $error("rsp_router: response slot overflow");
    end

endmodule

// File: hw/mem_fabric_top.sv
`timescale 1ns/1ps

module mem_fabric_top #(
    parameter int ADDR_WORDS = 8
) (
    input  logic                           clk_i,
    input  logic                           rst_i,
    input  logic                           host_en_i,

    // Core data port
    input  logic                           core_req_valid_i,
    output logic                           core_req_ready_o,
    input  soc_mem_pkg::mem_op_e           core_op_i,
    input  logic [soc_mem_pkg::ADDR_W-1:0] core_addr_i,
    input  logic [soc_mem_pkg::BE_W-1:0]   core_be_i,
    input  logic [soc_mem_pkg::DATA_W-1:0] core_wdata_i,
    output logic                           core_rsp_valid_o,
    input  logic                           core_rsp_ready_i,
    output logic [soc_mem_pkg::DATA_W-1:0] core_rsp_rdata_o,
    output logic                           core_rsp_err_o,

    // Host port
    input  logic                           host_req_valid_i,
    output logic                           host_req_ready_o,
    input  soc_mem_pkg::mem_op_e           host_op_i,
    input  logic [soc_mem_pkg::ADDR_W-1:0] host_addr_i,
    input  logic [soc_mem_pkg::BE_W-1:0]   host_be_i,
    input  logic [soc_mem_pkg::DATA_W-1:0] host_wdata_i,
    output logic                           host_rsp_valid_o,
    input  logic                           host_rsp_ready_i,
    output logic [soc_mem_pkg::DATA_W-1:0] host_rsp_rdata_o,
    output logic                           host_rsp_err_o,

    output logic                           illegal_o
);

    logic                           host_valid_rm;
    logic [soc_mem_pkg::ADDR_W-1:0] host_addr_rm;
    logic                           host_in_window;
    logic                           core_credit;
    logic                           host_credit;

    // Stage and result buses
    logic                           stg_valid;
    soc_mem_pkg::mem_op_e           stg_op;
    logic [ADDR_WORDS-1:0]          stg_index;
    logic [soc_mem_pkg::BE_W-1:0]   stg_be;
    logic [soc_mem_pkg::DATA_W-1:0] stg_wdata;
    logic                           stg_err;
    soc_mem_pkg::port_id_e          stg_tag;
    logic                           res_valid;
    logic [soc_mem_pkg::DATA_W-1:0] res_rdata;
    logic                           res_err;
    soc_mem_pkg::port_id_e          res_tag;

    ////////////////////////////////////////////////////////////////////////////
    // Request side
    ////////////////////////////////////////////////////////////////////////////

    host_addr_remap #(.ADDR_WORDS(ADDR_WORDS)) i_host_addr_remap (
        .host_en_i   (host_en_i),
        .req_valid_i (host_req_valid_i),
        .addr_i      (host_addr_i),
        .req_valid_o (host_valid_rm),
        .addr_o      (host_addr_rm),
        .in_window_o (host_in_window)
    );

    req_arbiter #(.ADDR_WORDS(ADDR_WORDS)) i_req_arbiter (
        .core_valid_i     (core_req_valid_i),
        .core_op_i        (core_op_i),
        .core_addr_i      (core_addr_i),
        .core_be_i        (core_be_i),
        .core_wdata_i     (core_wdata_i),
        .core_ready_o     (core_req_ready_o),
        .host_valid_i     (host_valid_rm),
        .host_op_i        (host_op_i),
        .host_addr_i      (host_addr_rm),
        .host_in_window_i (host_in_window),
        .host_be_i        (host_be_i),
        .host_wdata_i     (host_wdata_i),
        .host_ready_o     (host_req_ready_o),
        .core_credit_i    (core_credit),
        .host_credit_i    (host_credit),
        .stg_valid_o      (stg_valid),
        .stg_op_o         (stg_op),
        .stg_index_o      (stg_index),
        .stg_be_o         (stg_be),
        .stg_wdata_o      (stg_wdata),
        .stg_err_o        (stg_err),
        .stg_tag_o        (stg_tag)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Memory and response side
    ////////////////////////////////////////////////////////////////////////////

    sram_bank #(.ADDR_WORDS(ADDR_WORDS)) i_sram_bank (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .stg_valid_i (stg_valid),
        .stg_op_i    (stg_op),
        .stg_index_i (stg_index),
        .stg_be_i    (stg_be),
        .stg_wdata_i (stg_wdata),
        .stg_err_i   (stg_err),
        .stg_tag_i   (stg_tag),
        .res_valid_o (res_valid),
        .res_rdata_o (res_rdata),
        .res_err_o   (res_err),
        .res_tag_o   (res_tag)
    );

    rsp_router i_rsp_router (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .stg_valid_i      (stg_valid),
        .stg_tag_i        (stg_tag),
        .res_valid_i      (res_valid),
        .res_rdata_i      (res_rdata),
        .res_err_i        (res_err),
        .res_tag_i        (res_tag),
        .core_rsp_ready_i (core_rsp_ready_i),
        .host_rsp_ready_i (host_rsp_ready_i),
        .core_rsp_valid_o (core_rsp_valid_o),
        .core_rsp_rdata_o (core_rsp_rdata_o),
        .core_rsp_err_o   (core_rsp_err_o),
        .host_rsp_valid_o (host_rsp_valid_o),
        .host_rsp_rdata_o (host_rsp_rdata_o),
        .host_rsp_err_o   (host_rsp_err_o),
        .core_credit_o    (core_credit),
        .host_credit_o    (host_credit),
        .illegal_o        (illegal_o)
    );

endmodule

// File: testbench/tb_mem_fabric_util.svh
////////////////////////////////////////////////////////////////////////////
// Reference memory model
////////////////////////////////////////////////////////////////////////////

localparam logic [31:0] WINDOW_BYTES = 32'd4 << ADDR_WORDS;

// One entry per word, four bytes each
logic [7:0] ref_mem [2**ADDR_WORDS][4];

// Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
function automatic logic [31:0] lfsr_take(inout logic [31:0] state, input int nbits);
    logic [31:0] bits;
    logic        fb;
    bits = '0;
    for (int i = 0; i < nbits; i++) begin
        fb    = state[31] ^ state[21] ^ state[1] ^ state[0];
        state = {state[30:0], fb};
        bits  = {bits[30:0], fb};
    end
    return bits;
endfunction

// Preload pattern, every index bit shows up in the word
function automatic logic [31:0] fill_word(input int i);
    return 32'(i) * 32'h0101_0101 ^ 32'h3c5a_96e1;
endfunction

// Host window 0x3000_0000 up to 0x8000_0000 lands on the SRAM
function automatic logic [31:0] host_remap(input logic [31:0] addr);
    if (addr >= soc_mem_pkg::HOST_REMAP_LO && addr < soc_mem_pkg::HOST_REMAP_HI) begin
        return {soc_mem_pkg::REMAP_NIBBLE, addr[27:0]};
    end
    return addr;
endfunction

// Applies one accepted request, returns {err, data}
function automatic logic [32:0] ref_access(input soc_mem_pkg::mem_op_e op,
                                           input logic [31:0] addr,
                                           input logic [3:0] be,
                                           input logic [31:0] wdata);
    logic [31:0]           offset;
    logic [ADDR_WORDS-1:0] idx;
    offset = addr - soc_mem_pkg::SRAM_BASE;
    if (offset >= WINDOW_BYTES) begin
        return {1'b1, 32'h0};
    end
    idx = offset[ADDR_WORDS+1:2];
    if (op == soc_mem_pkg::OP_READ) begin
        return {1'b0, ref_mem[idx][3], ref_mem[idx][2], ref_mem[idx][1], ref_mem[idx][0]};
    end
    for (int b = 0; b < 4; b++) begin
        if (be[b]) begin
            ref_mem[idx][b] = wdata[b*8 +: 8];
        end
    end
    // Writes come back with zero data
    return {1'b0, 32'h0};
endfunction

task automatic check_value(input string what, input logic [32:0] got,
                           input logic [32:0] exp);
    if (got !== exp) begin
        $display("FAILED at %0t: %s, got %h, expected %h", $time, what, got, exp);
        stop_on_error();
    end
endtask

// File: testbench/tb_mem_fabric.sv
`timescale 1ns/1ps

module tb_mem_fabric;

    localparam int ADDR_WORDS = 8;
    localparam int TIMEOUT    = 1000;

    logic                 clk_i;
    logic                 rst_i;
    logic                 host_en_i;
    logic                 core_req_valid_i;
    logic                 core_req_ready_o;
    soc_mem_pkg::mem_op_e core_op_i;
    logic [31:0]          core_addr_i;
    logic [3:0]           core_be_i;
    logic [31:0]          core_wdata_i;
    logic                 core_rsp_valid_o;
    logic                 core_rsp_ready_i;
    logic [31:0]          core_rsp_rdata_o;
    logic                 core_rsp_err_o;
    logic                 host_req_valid_i;
    logic                 host_req_ready_o;
    soc_mem_pkg::mem_op_e host_op_i;
    logic [31:0]          host_addr_i;
    logic [3:0]           host_be_i;
    logic [31:0]          host_wdata_i;
    logic                 host_rsp_valid_o;
    logic                 host_rsp_ready_i;
    logic [31:0]          host_rsp_rdata_o;
    logic                 host_rsp_err_o;
    logic                 illegal_o;

    logic [32:0] core_exp_q[$];
    logic [32:0] host_exp_q[$];
    logic [32:0] last_core_rsp;
    logic [32:0] last_host_rsp;
    logic [31:0] rng;
    logic [31:0] core_seed;
    logic [31:0] host_seed;
    logic [31:0] ready_seed;
    logic        traffic_on;

    `include "tb_mem_fabric_util.svh"

    mem_fabric_top #(.ADDR_WORDS(ADDR_WORDS)) UUT (.*);

    always #4 clk_i = ~clk_i;

    task automatic stop_on_error();
        $display("Done: errors found");
        $fatal(1, "stopping at first error");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Acceptance monitor and response compare
    ////////////////////////////////////////////////////////////////////////////

    // Sampled mid-cycle where every handshake has settled before the next edge
    always @(negedge clk_i) begin
        if (!rst_i) begin
            if (core_req_valid_i && core_req_ready_o && host_req_valid_i && host_req_ready_o) begin
                $display("Core and host requests were accepted in the same cycle");
                stop_on_error();
            end
            if (core_req_valid_i && core_req_ready_o) begin
                core_exp_q.push_back(ref_access(core_op_i, core_addr_i, core_be_i, core_wdata_i));
            end
            if (host_req_valid_i && host_req_ready_o) begin
                host_exp_q.push_back(ref_access(host_op_i, host_remap(host_addr_i),
                                                host_be_i, host_wdata_i));
            end
            if (core_rsp_valid_o && core_rsp_ready_i) begin
                if (core_exp_q.size() == 0) begin
                    $display("Core port returned a response with nothing outstanding");
                    stop_on_error();
                end else begin
                    last_core_rsp = {core_rsp_err_o, core_rsp_rdata_o};
                    check_value("core response", last_core_rsp, core_exp_q.pop_front());
                end
            end
            if (host_rsp_valid_o && host_rsp_ready_i) begin
                if (host_exp_q.size() == 0) begin
                    $display("Host port returned a response with nothing outstanding");
                    stop_on_error();
                end else begin
                    last_host_rsp = {host_rsp_err_o, host_rsp_rdata_o};
                    check_value("host response", last_host_rsp, host_exp_q.pop_front());
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus tasks enter and leave 1 ns after a rising edge
    ////////////////////////////////////////////////////////////////////////////

    task automatic send_req(input soc_mem_pkg::port_id_e port, input soc_mem_pkg::mem_op_e op,
                            input logic [31:0] addr, input logic [3:0] be,
                            input logic [31:0] wdata);
        int waited;
        waited = 0;
        if (port == soc_mem_pkg::PORT_HOST) begin
            host_req_valid_i = 1'b1;
            host_op_i        = op;
            host_addr_i      = addr;
            host_be_i        = be;
            host_wdata_i     = wdata;
        end else begin
            core_req_valid_i = 1'b1;
            core_op_i        = op;
            core_addr_i      = addr;
            core_be_i        = be;
            core_wdata_i     = wdata;
        end
        @(negedge clk_i);
        while (!(port == soc_mem_pkg::PORT_HOST ? host_req_ready_o : core_req_ready_o)) begin
            if (waited > TIMEOUT) begin
                $display("Timeout: a request on port %0d was never accepted", port);
                stop_on_error();
            end else begin
                waited++;
                @(negedge clk_i);
            end
        end
        @(posedge clk_i);
        #1;
        if (port == soc_mem_pkg::PORT_HOST) begin
            host_req_valid_i = 1'b0;
        end else begin
            core_req_valid_i = 1'b0;
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (core_exp_q.size() != 0 || host_exp_q.size() != 0) begin
            if (waited > TIMEOUT) begin
                $display("Timeout: expected responses did not drain");
                stop_on_error();
            end else begin
                waited++;
                @(posedge clk_i);
                #1;
            end
        end
    endtask

    task automatic random_traffic(input soc_mem_pkg::port_id_e port, input logic [31:0] seed,
                                  input int count);
        logic [31:0]          state;
        logic [31:0]          r;
        logic [31:0]          idx;
        logic [31:0]          addr;
        soc_mem_pkg::mem_op_e op;
        state = seed;
        for (int n = 0; n < count; n++) begin
            r = lfsr_take(state, 2);
            repeat (r) begin
                @(posedge clk_i);
                #1;
            end
            idx = lfsr_take(state, ADDR_WORDS);
            r   = lfsr_take(state, 4);
            if (port == soc_mem_pkg::PORT_CORE) begin
                addr = (r == 0) ? 32'h0000_0100 : soc_mem_pkg::SRAM_BASE + (idx << 2);
            end else if (r == 0) begin
                addr = 32'h9000_0000 + (idx << 2);
            end else begin
                // Top nibble from 3 to 8 covers remapped and direct addresses
                addr = {4'(3 + r % 6), 28'(idx << 2)};
            end
            r = lfsr_take(state, 1);
            if (r[0]) begin
                op = soc_mem_pkg::OP_WRITE;
            end else begin
                op = soc_mem_pkg::OP_READ;
            end
            send_req(port, op, addr, 4'(lfsr_take(state, 4)), lfsr_take(state, 32));
        end
    endtask

    task automatic toggle_rsp_ready(input logic [31:0] seed);
        logic [31:0] state;
        logic [31:0] r;
        int          cycles;
        state  = seed;
        cycles = 0;
        while (traffic_on) begin
            if (cycles > 20 * TIMEOUT) begin
                $display("Timeout: random traffic did not finish");
                stop_on_error();
            end else begin
                r = lfsr_take(state, 2);
                core_rsp_ready_i = r[0];
                host_rsp_ready_i = r[1];
                cycles++;
                @(posedge clk_i);
                #1;
            end
        end
        core_rsp_ready_i = 1'b1;
        host_rsp_ready_i = 1'b1;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        clk_i            = 1'b0;
        rst_i            = 1'b1;
        host_en_i        = 1'b1;
        core_req_valid_i = 1'b0;
        core_op_i        = soc_mem_pkg::OP_READ;
        core_addr_i      = '0;
        core_be_i        = '0;
        core_wdata_i     = '0;
        core_rsp_ready_i = 1'b1;
        host_req_valid_i = 1'b0;
        host_op_i        = soc_mem_pkg::OP_READ;
        host_addr_i      = '0;
        host_be_i        = '0;
        host_wdata_i     = '0;
        host_rsp_ready_i = 1'b1;
        traffic_on       = 1'b0;
        rng              = 32'hbacf;
        repeat (5) @(posedge clk_i);
        #1;
        rst_i = 1'b0;

        @(negedge clk_i);
        check_value("core rsp_valid after reset", 33'(core_rsp_valid_o), 33'd0);
        check_value("host rsp_valid after reset", 33'(host_rsp_valid_o), 33'd0);
        check_value("illegal_o after reset", 33'(illegal_o), 33'd0);
        check_value("core req_ready after reset", 33'(core_req_ready_o), 33'd1);
        @(posedge clk_i);
        #1;

        // Whole SRAM gets a known pattern
        for (int i = 0; i < 2**ADDR_WORDS; i++) begin
            send_req(soc_mem_pkg::PORT_CORE, soc_mem_pkg::OP_WRITE,
                     soc_mem_pkg::SRAM_BASE + 32'(i * 4), 4'hf, fill_word(i));
        end
        wait_drain();

        // Byte enables merge into one word
        send_req(soc_mem_pkg::PORT_CORE, soc_mem_pkg::OP_WRITE,
                 32'h8000_0040, 4'hf, 32'h1122_3344);
        send_req(soc_mem_pkg::PORT_CORE, soc_mem_pkg::OP_WRITE,
                 32'h8000_0040, 4'h1, 32'haaaa_aaee);
        send_req(soc_mem_pkg::PORT_CORE, soc_mem_pkg::OP_WRITE,
                 32'h8000_0040, 4'h4, 32'h55cc_5555);
        send_req(soc_mem_pkg::PORT_CORE, soc_mem_pkg::OP_READ, 32'h8000_0040, 4'hf, 32'h0);
        wait_drain();
        check_value("merged byte read", last_core_rsp, {1'b0, 32'h11cc_33ee});

        // Host remap window and direct SRAM address
        send_req(soc_mem_pkg::PORT_HOST, soc_mem_pkg::OP_WRITE,
                 32'h3000_0010, 4'hf, 32'hdead_beef);
        send_req(soc_mem_pkg::PORT_CORE, soc_mem_pkg::OP_READ, 32'h8000_0010, 4'hf, 32'h0);
        wait_drain();
        check_value("core read of remapped host write", last_core_rsp, {1'b0, 32'hdead_beef});
        send_req(soc_mem_pkg::PORT_HOST, soc_mem_pkg::OP_WRITE,
                 32'h8000_0020, 4'hf, 32'h0bad_f00d);
        send_req(soc_mem_pkg::PORT_CORE, soc_mem_pkg::OP_READ, 32'h8000_0020, 4'hf, 32'h0);
        wait_drain();
        check_value("core read of direct host write", last_core_rsp, {1'b0, 32'h0bad_f00d});

        // Out of window on both ports
        send_req(soc_mem_pkg::PORT_CORE, soc_mem_pkg::OP_READ, 32'h0000_0100, 4'hf, 32'h0);
        wait_drain();
        check_value("core illegal read", last_core_rsp, {1'b1, 32'h0});
        send_req(soc_mem_pkg::PORT_HOST, soc_mem_pkg::OP_WRITE,
                 32'h9000_0000, 4'hf, 32'hffff_ffff);
        wait_drain();
        check_value("host illegal write", last_host_rsp, {1'b1, 32'h0});
        send_req(soc_mem_pkg::PORT_CORE, soc_mem_pkg::OP_READ, 32'h8000_0000, 4'hf, 32'h0);
        wait_drain();
        check_value("word 0 after illegal write", last_core_rsp, {1'b0, fill_word(0)});
        check_value("illegal_o after error", 33'(illegal_o), 33'd1);

        // Host disabled while the core keeps working
        host_en_i        = 1'b0;
        host_req_valid_i = 1'b1;
        host_op_i        = soc_mem_pkg::OP_WRITE;
        host_addr_i      = 32'h8000_0000;
        host_be_i        = 4'hf;
        host_wdata_i     = 32'hffff_ffff;
        fork
            repeat (40) begin
                @(negedge clk_i);
                check_value("host req_ready while disabled", 33'(host_req_ready_o), 33'd0);
            end
            for (int i = 0; i < 8; i++) begin
                send_req(soc_mem_pkg::PORT_CORE, soc_mem_pkg::OP_READ,
                         soc_mem_pkg::SRAM_BASE + 32'(i * 4), 4'hf, 32'h0);
            end
        join
        @(posedge clk_i);
        #1;
        host_req_valid_i = 1'b0;
        host_en_i        = 1'b1;
        wait_drain();
        check_value("core read with host disabled", last_core_rsp, {1'b0, fill_word(7)});

        // Random traffic on both ports with back-pressure
        core_seed  = lfsr_take(rng, 32);
        host_seed  = lfsr_take(rng, 32);
        ready_seed = lfsr_take(rng, 32);
        traffic_on = 1'b1;
        fork
            begin
                fork
                    random_traffic(soc_mem_pkg::PORT_CORE, core_seed, 300);
                    random_traffic(soc_mem_pkg::PORT_HOST, host_seed, 300);
                join
                traffic_on = 1'b0;
            end
            toggle_rsp_ready(ready_seed);
        join
        wait_drain();
        check_value("illegal_o still set", 33'(illegal_o), 33'd1);

        $display("Done: no errors");
        $finish;
    end

endmodule

// File: sources.f
+incdir+testbench
hw/soc_mem_pkg.sv
hw/host_addr_remap.sv
hw/req_arbiter.sv
hw/sram_bank.sv
hw/rsp_router.sv
hw/mem_fabric_top.sv
testbench/tb_mem_fabric.sv

// File: Makefile
SRCS := $(shell grep -v '^+' sources.f) testbench/tb_mem_fabric_util.svh

obj_dir/Vtb_mem_fabric: sources.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module tb_mem_fabric -f sources.f

.PHONY: run clean

run: obj_dir/Vtb_mem_fabric
	@out=$$(./obj_dir/Vtb_mem_fabric); echo "$$out"; echo "$$out" | grep -q "Done: no errors"

clean:
	rm -rf obj_dir
